/* logic/FetchTypes.sv */
// Fetch front end widths shared by the predictor.
// Addresses are byte addresses and instructions are 4-byte aligned.
// The front end fetches two instructions and retires two results per cycle.
`default_nettype none

package FetchTypes;

    // Byte address width.
    localparam int ADDR_WIDTH = 16;

    typedef logic [ADDR_WIDTH-1:0] AddrPath;

    // Low address bits that select a byte inside an instruction.
    localparam int INSN_ADDR_BIT_WIDTH = 2;
    localparam int INSN_BYTE_WIDTH = 4;

    // Instructions fetched per cycle.
    localparam int FETCH_WIDTH = 2;

    // Branch results retired per cycle.
    localparam int RESULT_WIDTH = 2;

endpackage

`default_nettype wire

/* logic/PredictorTypes.sv */
// Gshare table, history and write queue definitions.
// The history width must not exceed the table index width.
`default_nettype none

package PredictorTypes;

    localparam int GLOBAL_HISTORY_WIDTH = 4;
    localparam int PHT_INDEX_WIDTH = 6;
    localparam int PHT_ENTRY_WIDTH = 2;

    typedef logic [GLOBAL_HISTORY_WIDTH-1:0] GlobalHistoryPath;
    typedef logic [PHT_INDEX_WIDTH-1:0] PhtIndexPath;
    typedef logic [PHT_ENTRY_WIDTH-1:0] PhtEntryPath;

    localparam int PHT_ENTRY_NUM = 64;
    localparam PhtEntryPath PHT_ENTRY_MAX = 2'd3;
    // Weakly taken.
    localparam PhtEntryPath PHT_INIT_VALUE = 2'd2;

    // Write port 0 takes direct updates, port 1 drains the queue.
    localparam int PHT_WRITE_NUM = 2;
    localparam int PHT_DIRECT_PORT = 0;
    localparam int PHT_QUEUE_PORT = 1;

    localparam int PHT_QUEUE_SIZE = 4;
    localparam int PHT_QUEUE_POINTER_WIDTH = 2;
    typedef logic [PHT_QUEUE_POINTER_WIDTH-1:0] PhtQueuePointerPath;
    // One extra bit so a full queue can be told from an empty one.
    typedef logic [PHT_QUEUE_POINTER_WIDTH:0] PhtQueueCountPath;

    typedef struct packed {
        PhtIndexPath index;
        PhtEntryPath value;
    } PhtWriteEntry;

    typedef enum logic {Walking, Ready} InitState;

endpackage

`default_nettype wire

/* logic/PhtAccessIf.sv */
// Read and write ports of the pattern history table.
// One read port per fetch slot, values arrive one cycle after the index.
// The core drives write port 0 and the write queue drives port 1.
`timescale 1ns/1ps
`default_nettype none

interface PhtAccessIf
    import FetchTypes::*, PredictorTypes::*;
();

    // Read side.
    PhtIndexPath readIndex [FETCH_WIDTH];
    PhtEntryPath readValue [FETCH_WIDTH];

    // Write side.
    logic        writeEnable [PHT_WRITE_NUM];
    PhtIndexPath writeIndex [PHT_WRITE_NUM];
    PhtEntryPath writeValue [PHT_WRITE_NUM];

    modport Core (
        output readIndex,
        output writeEnable,
        output writeIndex,
        output writeValue,
        input  readValue
    );

    // Only the queue port element is driven through this view.
    modport Queue (
        output writeEnable,
        output writeIndex,
        output writeValue
    );

    modport Table (
        input  readIndex,
        input  writeEnable,
        input  writeIndex,
        input  writeValue,
        output readValue
    );

endinterface

`default_nettype wire

/* logic/PatternTable.sv */
// Counter storage of the gshare predictor.
// Reads are registered, so a read that hits a write returns the old value.
// Port 0 wins when both write ports target one entry.
// Counters are undefined until the predictor's initialization walk has run.
`timescale 1ns/1ps
`default_nettype none

module PatternTable
    import FetchTypes::*, PredictorTypes::*;
(
    input logic clock,
    PhtAccessIf.Table pht
);

    PhtEntryPath entries [PHT_ENTRY_NUM];

    // Highest port is written first so that port 0 lands last.
    always_ff @(posedge clock) begin
        for (int w = PHT_WRITE_NUM - 1; w >= 0; w--) begin
            if (pht.writeEnable[w]) begin
                entries[pht.writeIndex[w]] <= pht.writeValue[w];
            end
        end
    end

    // One registered read per fetch slot.
    always_ff @(posedge clock) begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            pht.readValue[i] <= entries[pht.readIndex[i]];
        end
    end

endmodule

`default_nettype wire

/* logic/PhtWriteQueue.sv */
// Holds deferred counter writes until write port 1 is free.
// A push while the queue is full is dropped, counters are only hints.
// The head entry leaves only in cycles where port 0 is idle.
`timescale 1ns/1ps
`default_nettype none

module PhtWriteQueue
    import PredictorTypes::*;
(
    input  logic         clock,
    input  logic         reset,
    input  logic         push,
    input  PhtWriteEntry pushEntry,
    input  logic         portBusy,
    output logic         full,
    PhtAccessIf.Queue    pht
);

    PhtWriteEntry       entries [PHT_QUEUE_SIZE];
    PhtQueuePointerPath headPtr;
    PhtQueuePointerPath tailPtr;
    PhtQueueCountPath   count;
    logic               pushAccept;
    logic               pop;

    assign full = (count == PhtQueueCountPath'(PHT_QUEUE_SIZE));
    assign pushAccept = push && !full;
    assign pop = (count != '0) && !portBusy;

    // Head entry goes out on the queue write port.
    assign pht.writeEnable[PHT_QUEUE_PORT] = pop;
    assign pht.writeIndex[PHT_QUEUE_PORT] = entries[headPtr].index;
    assign pht.writeValue[PHT_QUEUE_PORT] = entries[headPtr].value;

    always_ff @(posedge clock) begin
        if (pushAccept) begin
            entries[tailPtr] <= pushEntry;
        end
    end

    // Pointers wrap naturally since the size is a power of two.
    always_ff @(posedge clock) begin
        if (reset) begin
            headPtr <= '0;
            tailPtr <= '0;
            count <= '0;
        end else begin
            if (pushAccept) begin
                tailPtr <= tailPtr + 1'b1;
            end
            if (pop) begin
                headPtr <= headPtr + 1'b1;
            end
            case ({pushAccept, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/GsharePredictor.sv */
// Gshare direction prediction, global history and counter updates.
// Index is the word address with the history XORed into its top bits.
// After reset a walk writes every counter to weakly taken; updates wait for ready.
// The history scan stops at the first slot predicted taken.
`timescale 1ns/1ps
`default_nettype none

module GsharePredictor
    import FetchTypes::*, PredictorTypes::*;
(
    input  logic                                clock,
    input  logic                                reset,
    input  AddrPath                             predNextPc,
    input  logic [FETCH_WIDTH-1:0]              btbHit,
    input  logic [FETCH_WIDTH-1:0]              isCondBr,
    input  logic [FETCH_WIDTH-1:0]              historyEnable,
    output logic [FETCH_WIDTH-1:0]              predTaken,
    output GlobalHistoryPath                    globalHistory,
    output PhtEntryPath [FETCH_WIDTH-1:0]       phtPrevValue,
    output logic                                ready,
    input  logic [RESULT_WIDTH-1:0]             resultValid,
    input  logic [RESULT_WIDTH-1:0]             resultTaken,
    input  logic [RESULT_WIDTH-1:0]             resultMispred,
    input  AddrPath [RESULT_WIDTH-1:0]          resultAddr,
    input  GlobalHistoryPath [RESULT_WIDTH-1:0] resultHistory,
    input  PhtEntryPath [RESULT_WIDTH-1:0]      resultPrevValue,
    input  logic                                recoverHistory,
    input  GlobalHistoryPath                    recoveredHistory,
    output logic                                queuePush,
    output PhtWriteEntry                        queueEntry,
    output logic                                portBusy,
    PhtAccessIf.Core                            pht
);

    GlobalHistoryPath                 historyReg;
    GlobalHistoryPath                 nextHistory;
    logic                             mispredReg;
    logic                             hasMispred;
    InitState                         initState;
    PhtIndexPath                      initIndex;
    PhtIndexPath [RESULT_WIDTH-1:0]   updateIndex;
    PhtEntryPath [RESULT_WIDTH-1:0]   updateValue;
    logic                             directEnable;
    PhtIndexPath                      directIndex;
    PhtEntryPath                      directValue;

    function automatic PhtIndexPath hashIndex(AddrPath addr, GlobalHistoryPath history);
        PhtIndexPath index;
        index = addr[PHT_INDEX_WIDTH + INSN_ADDR_BIT_WIDTH - 1:INSN_ADDR_BIT_WIDTH];
        index[PHT_INDEX_WIDTH-1 -: GLOBAL_HISTORY_WIDTH] =
            index[PHT_INDEX_WIDTH-1 -: GLOBAL_HISTORY_WIDTH] ^ history;
        return index;
    endfunction

    assign ready = (initState == Ready);
    assign globalHistory = historyReg;
    assign hasMispred = |(resultValid & resultMispred);

    // Counter MSB decides conditional slots, unconditional hits are always taken.
    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            predTaken[i] = btbHit[i] && (pht.readValue[i][PHT_ENTRY_WIDTH-1] || !isCondBr[i]);
            phtPrevValue[i] = pht.readValue[i];
        end
    end

    always_comb begin
        logic scanDone;
        scanDone = 1'b0;
        nextHistory = historyReg;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            if (!scanDone) begin
                // History is frozen for one cycle after a misprediction.
                if (btbHit[i] && isCondBr[i] && historyEnable[i] && !mispredReg) begin
                    nextHistory = {nextHistory[GLOBAL_HISTORY_WIDTH-2:0], predTaken[i]};
                end
                scanDone = predTaken[i];
            end
        end
        if (recoverHistory) begin
            nextHistory = recoveredHistory;
        end
    end

    // Reads for the next fetch group use the freshly computed history.
    always_comb begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            pht.readIndex[i] = hashIndex(predNextPc + AddrPath'(i * INSN_BYTE_WIDTH), nextHistory);
        end
    end

    // Saturating two-bit counter step for each retired result.
    always_comb begin
        for (int r = 0; r < RESULT_WIDTH; r++) begin
            updateIndex[r] = hashIndex(resultAddr[r], resultHistory[r]);
            if (resultTaken[r]) begin
                updateValue[r] = (resultPrevValue[r] == PHT_ENTRY_MAX) ?
                    PHT_ENTRY_MAX : resultPrevValue[r] + 1'b1;
            end else begin
                updateValue[r] = (resultPrevValue[r] == '0) ?
                    '0 : resultPrevValue[r] - 1'b1;
            end
        end
    end

    // First valid result writes directly, a second one is deferred.
    always_comb begin
        directEnable = 1'b0;
        directIndex = updateIndex[0];
        directValue = updateValue[0];
        queuePush = 1'b0;
        queueEntry = '{index: updateIndex[RESULT_WIDTH-1], value: updateValue[RESULT_WIDTH-1]};
        for (int r = 0; r < RESULT_WIDTH; r++) begin
            if (ready && resultValid[r]) begin
                if (!directEnable) begin
                    directEnable = 1'b1;
                    directIndex = updateIndex[r];
                    directValue = updateValue[r];
                end else begin
                    queuePush = 1'b1;
                    queueEntry = '{index: updateIndex[r], value: updateValue[r]};
                end
            end
        end
        // Initialization walk owns port 0 until ready.
        if (!ready) begin
            directEnable = 1'b1;
            directIndex = initIndex;
            directValue = PHT_INIT_VALUE;
        end
    end

    assign pht.writeEnable[PHT_DIRECT_PORT] = directEnable;
    assign pht.writeIndex[PHT_DIRECT_PORT] = directIndex;
    assign pht.writeValue[PHT_DIRECT_PORT] = directValue;
    assign portBusy = directEnable;

    always_ff @(posedge clock) begin
        if (reset) begin
            historyReg <= '0;
            mispredReg <= 1'b0;
            initState <= Walking;
            initIndex <= '0;
        end else begin
            historyReg <= nextHistory;
            mispredReg <= hasMispred;
            if (initState == Walking) begin
                initIndex <= initIndex + 1'b1;
                if (initIndex == PhtIndexPath'(PHT_ENTRY_NUM - 1)) begin
                    initState <= Ready;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* logic/BranchPredictorTop.sv */
// Branch direction predictor with the table and write queue attached.
// Fetch and result inputs are single-cycle strobes with no back-pressure.
// Ready stays low for one walk over the table after reset.
`timescale 1ns/1ps
`default_nettype none

module BranchPredictorTop
    import FetchTypes::*, PredictorTypes::*;
(
    input  logic                                clock,
    input  logic                                reset,
    input  AddrPath                             predNextPc,
    input  logic [FETCH_WIDTH-1:0]              btbHit,
    input  logic [FETCH_WIDTH-1:0]              isCondBr,
    input  logic [FETCH_WIDTH-1:0]              historyEnable,
    output logic [FETCH_WIDTH-1:0]              predTaken,
    output GlobalHistoryPath                    globalHistory,
    output PhtEntryPath [FETCH_WIDTH-1:0]       phtPrevValue,
    output logic                                ready,
    input  logic [RESULT_WIDTH-1:0]             resultValid,
    input  logic [RESULT_WIDTH-1:0]             resultTaken,
    input  logic [RESULT_WIDTH-1:0]             resultMispred,
    input  AddrPath [RESULT_WIDTH-1:0]          resultAddr,
    input  GlobalHistoryPath [RESULT_WIDTH-1:0] resultHistory,
    input  PhtEntryPath [RESULT_WIDTH-1:0]      resultPrevValue,
    input  logic                                recoverHistory,
    input  GlobalHistoryPath                    recoveredHistory
);

    logic         queuePush;
    PhtWriteEntry queueEntry;
    logic         portBusy;

    PhtAccessIf phtBus ();

    GsharePredictor predictor (
        .clock            (clock),
        .reset            (reset),
        .predNextPc       (predNextPc),
        .btbHit           (btbHit),
        .isCondBr         (isCondBr),
        .historyEnable    (historyEnable),
        .predTaken        (predTaken),
        .globalHistory    (globalHistory),
        .phtPrevValue     (phtPrevValue),
        .ready            (ready),
        .resultValid      (resultValid),
        .resultTaken      (resultTaken),
        .resultMispred    (resultMispred),
        .resultAddr       (resultAddr),
        .resultHistory    (resultHistory),
        .resultPrevValue  (resultPrevValue),
        .recoverHistory   (recoverHistory),
        .recoveredHistory (recoveredHistory),
        .queuePush        (queuePush),
        .queueEntry       (queueEntry),
        .portBusy         (portBusy),
        .pht              (phtBus.Core)
    );

    // Full only matters inside the queue, where it drops pushes.
    PhtWriteQueue writeQueue (
        .clock     (clock),
        .reset     (reset),
        .push      (queuePush),
        .pushEntry (queueEntry),
        .portBusy  (portBusy),
        .full      (),
        .pht       (phtBus.Queue)
    );

    PatternTable patternTable (
        .clock (clock),
        .pht   (phtBus.Table)
    );

endmodule

`default_nettype wire

/* test/ClockGen.sv */
// Free running testbench clock with a 10 ns period.
`timescale 1ns/1ps
`default_nettype none

module ClockGen (
    output logic clock
);

    initial begin
        clock = 1'b0;
    end

    always #5 clock = ~clock;

endmodule

`default_nettype wire

/* test/GshareTb.sv */
// Testbench for the gshare predictor with its own counter, queue and history model.
// History is pinned with recoverHistory before each table read.
`timescale 1ns/1ps
`default_nettype none

module GshareTb
    import FetchTypes::*, PredictorTypes::*;
();

    // Init walk plus roughly 700 test cycles, with margin.
    localparam int TIMEOUT_CYCLES = 2000;

    logic                                clock;
    logic                                reset;
    AddrPath                             predNextPc;
    logic [FETCH_WIDTH-1:0]              btbHit;
    logic [FETCH_WIDTH-1:0]              isCondBr;
    logic [FETCH_WIDTH-1:0]              historyEnable;
    logic [FETCH_WIDTH-1:0]              predTaken;
    GlobalHistoryPath                    globalHistory;
    PhtEntryPath [FETCH_WIDTH-1:0]       phtPrevValue;
    logic                                ready;
    logic [RESULT_WIDTH-1:0]             resultValid;
    logic [RESULT_WIDTH-1:0]             resultTaken;
    logic [RESULT_WIDTH-1:0]             resultMispred;
    AddrPath [RESULT_WIDTH-1:0]          resultAddr;
    GlobalHistoryPath [RESULT_WIDTH-1:0] resultHistory;
    PhtEntryPath [RESULT_WIDTH-1:0]      resultPrevValue;
    logic                                recoverHistory;
    GlobalHistoryPath                    recoveredHistory;

    PhtEntryPath  refPht [PHT_ENTRY_NUM];
    PhtWriteEntry refQueue [$];
    logic [31:0]  rngState = 32'h449e;
    int           errorCount = 0;
    int           checkCount = 0;
    int           cycleCount = 0;
    logic         initDone = 1'b0;

    ClockGen clockGen (.clock(clock));

    BranchPredictorTop dut0 (.*);

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // Word address bits with the history folded into the top four.
    function automatic PhtIndexPath tableIndex(AddrPath addr, GlobalHistoryPath hist);
        PhtIndexPath idx;
        idx = addr[7:2];
        idx[5:2] = idx[5:2] ^ hist;
        return idx;
    endfunction

    function automatic PhtEntryPath stepCounter(PhtEntryPath prev, logic taken);
        if (taken) begin
            return (prev == 2'd3) ? 2'd3 : prev + 2'd1;
        end
        return (prev == 2'd0) ? 2'd0 : prev - 2'd1;
    endfunction

    task automatic checkValue(string name, logic [31:0] got, logic [31:0] expected);
        checkCount++;
        assert (got === expected) else begin
            errorCount++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, expected);
        end
    endtask

    // One cycle without updates, so the queue may drain one entry.
    task automatic idleCycle();
        @(posedge clock);
        resultValid <= '0;
        resultMispred <= '0;
        btbHit <= '0;
        recoverHistory <= 1'b0;
        if (refQueue.size() > 0) begin
            refPht[refQueue[0].index] = refQueue[0].value;
            void'(refQueue.pop_front());
        end
    endtask

    task automatic readAndCheck(AddrPath pc, GlobalHistoryPath hist);
        @(posedge clock);
        predNextPc <= pc;
        recoverHistory <= 1'b1;
        recoveredHistory <= hist;
        resultValid <= '0;
        btbHit <= '0;
        @(posedge clock);
        recoverHistory <= 1'b0;
        @(negedge clock);
        checkValue("globalHistory", 32'(globalHistory), 32'(hist));
        checkValue("phtPrevValue[0]", 32'(phtPrevValue[0]), 32'(refPht[tableIndex(pc, hist)]));
        checkValue("phtPrevValue[1]", 32'(phtPrevValue[1]),
            32'(refPht[tableIndex(pc + 16'd4, hist)]));
    endtask

    task automatic singleUpdate(AddrPath addr, GlobalHistoryPath hist, logic taken,
                                PhtEntryPath prev);
        @(posedge clock);
        resultValid <= 2'b01;
        resultMispred <= '0;
        resultTaken <= {1'b0, taken};
        resultAddr[0] <= addr;
        resultHistory[0] <= hist;
        resultPrevValue[0] <= prev;
        refPht[tableIndex(addr, hist)] = stepCounter(prev, taken);
    endtask

    // Back-to-back dual updates, then four idle cycles and readback.
    task automatic dualBurst(int cycles);
        AddrPath          addrs [$];
        GlobalHistoryPath hists [$];
        AddrPath          a0;
        AddrPath          a1;
        GlobalHistoryPath h0;
        GlobalHistoryPath h1;
        PhtEntryPath      p0;
        PhtEntryPath      p1;
        logic [1:0]       taken;
        for (int c = 0; c < cycles; c++) begin
            a0 = AddrPath'(nextRandom()) & 16'hfffc;
            a1 = AddrPath'(nextRandom()) & 16'hfffc;
            h0 = GlobalHistoryPath'(nextRandom());
            h1 = GlobalHistoryPath'(nextRandom());
            p0 = PhtEntryPath'(nextRandom());
            p1 = PhtEntryPath'(nextRandom());
            taken = 2'(nextRandom());
            @(posedge clock);
            resultValid <= 2'b11;
            resultMispred <= '0;
            resultTaken <= taken;
            resultAddr <= {a1, a0};
            resultHistory <= {h1, h0};
            resultPrevValue <= {p1, p0};
            refPht[tableIndex(a0, h0)] = stepCounter(p0, taken[0]);
            refQueue.push_back(PhtWriteEntry'{index: tableIndex(a1, h1),
                                              value: stepCounter(p1, taken[1])});
            addrs.push_back(a0);
            addrs.push_back(a1);
            hists.push_back(h0);
            hists.push_back(h1);
        end
        repeat (4) idleCycle();
        foreach (addrs[i]) begin
            readAndCheck(addrs[i], hists[i]);
        end
    endtask

    // Reads a fetch group, predicts it and checks the shifted history.
    task automatic predictAndShift(logic mispred);
        AddrPath           pc;
        GlobalHistoryPath  hist;
        GlobalHistoryPath  expHist;
        logic [1:0]        bh;
        logic [1:0]        cb;
        logic [1:0]        he;
        logic [1:0]        expTaken;
        PhtEntryPath [1:0] expValue;
        logic              scanDone;
        pc = AddrPath'(nextRandom()) & 16'hfffc;
        hist = GlobalHistoryPath'(nextRandom());
        bh = 2'(nextRandom());
        cb = 2'(nextRandom());
        he = 2'(nextRandom());
        expValue[0] = refPht[tableIndex(pc, hist)];
        expValue[1] = refPht[tableIndex(pc + 16'd4, hist)];
        @(posedge clock);
        predNextPc <= pc;
        recoverHistory <= 1'b1;
        recoveredHistory <= hist;
        btbHit <= '0;
        if (mispred) begin
            resultValid <= 2'b01;
            resultMispred <= 2'b01;
            resultTaken <= 2'b00;
            resultAddr[0] <= pc;
            resultHistory[0] <= hist;
            resultPrevValue[0] <= 2'd1;
            refPht[tableIndex(pc, hist)] = 2'd0;
        end
        @(posedge clock);
        recoverHistory <= 1'b0;
        resultValid <= '0;
        resultMispred <= '0;
        btbHit <= bh;
        isCondBr <= cb;
        historyEnable <= he;
        predNextPc <= AddrPath'(nextRandom());
        @(negedge clock);
        expHist = hist;
        scanDone = 1'b0;
        for (int i = 0; i < FETCH_WIDTH; i++) begin
            expTaken[i] = bh[i] && (expValue[i][1] || !cb[i]);
            if (!scanDone) begin
                if (bh[i] && cb[i] && he[i] && !mispred) begin
                    expHist = {expHist[2:0], expTaken[i]};
                end
                scanDone = expTaken[i];
            end
        end
        checkValue("globalHistory", 32'(globalHistory), 32'(hist));
        checkValue("phtPrevValue", 32'(phtPrevValue), 32'(expValue));
        checkValue("predTaken", 32'(predTaken), 32'(expTaken));
        @(posedge clock);
        btbHit <= '0;
        @(negedge clock);
        checkValue("globalHistory", 32'(globalHistory), 32'(expHist));
    endtask

    always @(posedge clock) begin
        cycleCount++;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    // Ready must stay high once the walk has ended.
    always @(negedge clock) begin
        if (initDone) begin
            checkValue("ready", 32'(ready), 32'd1);
        end
    end

    initial begin
        int lowCycles;
        logic taken;
        PhtEntryPath prev;
        AddrPath addr;
        GlobalHistoryPath hist;
        reset = 1'b1;
        predNextPc = '0;
        btbHit = '0;
        isCondBr = '0;
        historyEnable = '0;
        resultValid = '0;
        resultTaken = '0;
        resultMispred = '0;
        resultAddr = '0;
        resultHistory = '0;
        resultPrevValue = '0;
        recoverHistory = 1'b0;
        recoveredHistory = '0;
        repeat (8) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        checkValue("ready", 32'(ready), 32'd0);
        lowCycles = 0;
        while (!ready && lowCycles < 100) begin
            @(posedge clock);
            lowCycles++;
            @(negedge clock);
        end
        checkValue("ready latency", 32'(lowCycles), 32'd64);
        initDone = 1'b1;
        foreach (refPht[i]) begin
            refPht[i] = PHT_INIT_VALUE;
        end
        // Every index after the walk, two slots per read.
        for (int k = 0; k < PHT_ENTRY_NUM / 2; k++) begin
            readAndCheck(AddrPath'(k * 8), '0);
        end
        // The first four pin both saturation ends.
        for (int k = 0; k < 40; k++) begin
            addr = AddrPath'(nextRandom()) & 16'hfffc;
            hist = GlobalHistoryPath'(nextRandom());
            taken = (k < 4) ? k[0] : nextRandom() & 1;
            prev = (k < 4) ? (k[0] ? 2'd3 : 2'd0) : PhtEntryPath'(nextRandom());
            singleUpdate(addr, hist, taken, prev);
            idleCycle();
            readAndCheck(addr, hist);
        end
        for (int k = 0; k < 10; k++) begin
            dualBurst(1 + (k % 4));
        end
        for (int k = 0; k < 60; k++) begin
            predictAndShift((k % 5) == 4);
        end
        idleCycle();
        $display("Checks: %0d run, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
logic/FetchTypes.sv
logic/PredictorTypes.sv
logic/PhtAccessIf.sv
logic/PatternTable.sv
logic/PhtWriteQueue.sv
logic/GsharePredictor.sv
logic/BranchPredictorTop.sv
test/ClockGen.sv
test/GshareTb.sv

/* run.sh */
#!/bin/sh
# Builds the gshare testbench with Verilator, runs it and checks the log.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module GshareTb \
    -f build.f -o GshareSim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/GshareSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q '\*\* FAIL \*\*' "$LOG"; then
    exit 1
fi

if ! grep -q '\*\* PASS \*\*' "$LOG"; then
    echo "Simulation ended without a result line"
    exit 1
fi

exit 0
